// File: hw/bp_param_pkg.sv
package bp_param_pkg;

    // --------------------------------------------------
    // sizing
    // --------------------------------------------------
    localparam int unsigned PC_BITS  = 5;   // pc bits used for table index
    localparam int unsigned GR_BITS  = 5;   // global history length
    localparam int unsigned CNT_BITS = 2;   // saturating counter width

    // counter saturation value, all ones
    localparam int unsigned CNT_MAX = (1 << CNT_BITS) - 1;
    // taken / bimodal-bias threshold
    localparam int unsigned CNT_THR = (CNT_MAX == 1) ? CNT_MAX : (CNT_MAX >> 1);

    // --------------------------------------------------
    // widths with a meaning
    // --------------------------------------------------
    typedef logic [31:0]         pc_t;      // program counter
    typedef logic [CNT_BITS-1:0] cnt_t;     // one table counter
    typedef logic [GR_BITS-1:0]  ghr_t;     // global history register

    // --------------------------------------------------
    // encodings
    // --------------------------------------------------
    typedef enum logic {
        B_NT = 1'b0,    // not taken
        B_T  = 1'b1     // taken
    } branch_t;

    // table flavour, picks index formation and update rule
    typedef enum logic [2:0] {
        BP_BIMODAL,     // pc only
        BP_GLOBAL,      // history only
        BP_GSELECT,     // pc and history concatenated
        BP_GSHARE,      // pc xor history
        BP_COMBINED     // chooser between two components
    } bp_t;

    typedef enum logic [1:0] {
        MODE_COMBINED = 2'd0,
        MODE_BIMODAL  = 2'd1,
        MODE_GSHARE   = 2'd2
    } bp_mode_t;

endpackage

// File: hw/bp_pipe_pkg.sv
package bp_pipe_pkg;

    import bp_param_pkg::*;

    // --------------------------------------------------
    // speculation strobes, one cycle each
    // --------------------------------------------------
    typedef struct packed {
        logic enter;        // new branch accepted from decode
        logic resolve;      // in-flight branch resolved by execute
    } bp_spec_t;

    // --------------------------------------------------
    // tracker to tables
    // --------------------------------------------------
    typedef struct packed {
        pc_t      pc_dec;   // read side, branch in decode
        pc_t      pc_exe;   // update side, latched in-flight pc
        branch_t  br_res;   // real outcome, valid with resolve
        bp_spec_t spec;
    } bp_pipe_t;

    // component predictions, chooser and tracker both see them
    typedef struct packed {
        branch_t bp_1_p;    // bimodal
        branch_t bp_2_p;    // gshare
    } bp_comp_t;

    // --------------------------------------------------
    // config block outputs
    // --------------------------------------------------
    typedef struct packed {
        logic     enable;   // low forces not taken
        bp_mode_t mode;     // which prediction goes out
        logic     flush;    // one-cycle pulse
    } bp_cfg_t;

endpackage

// File: hw/bp_pht.sv
`timescale 1ns/1ps

module bp_pht #(
    parameter bp_param_pkg::bp_t BP_TYPE_SEL = bp_param_pkg::BP_BIMODAL,
    parameter int unsigned       PC_BITS     = bp_param_pkg::PC_BITS,
    parameter int unsigned       GR_BITS     = bp_param_pkg::GR_BITS,
    parameter int unsigned       CNT_BITS    = bp_param_pkg::CNT_BITS
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  bp_pipe_pkg::bp_pipe_t  pipe_in,
    input  bp_pipe_pkg::bp_comp_t  bp_comp_pred,
    output bp_param_pkg::branch_t  pred
);

    import bp_param_pkg::*;
    import bp_pipe_pkg::*;

    // --------------------------------------------------
    // sizing per table type
    // --------------------------------------------------
    localparam int unsigned IDX_BITS =
        ((BP_TYPE_SEL == BP_BIMODAL) || (BP_TYPE_SEL == BP_COMBINED)) ? PC_BITS :
        (BP_TYPE_SEL == BP_GLOBAL)  ? GR_BITS :
        (BP_TYPE_SEL == BP_GSELECT) ? (GR_BITS + PC_BITS) :
        ((GR_BITS > PC_BITS) ? GR_BITS : PC_BITS);          // gshare
    localparam int unsigned ENTRIES = 1 << IDX_BITS;

    localparam logic [CNT_BITS-1:0] TOP = CNT_BITS'(CNT_MAX);
    localparam logic [CNT_BITS-1:0] THR = CNT_BITS'(CNT_THR);

    logic                taken;
    logic [PC_BITS-1:0]  pc_rd;         // low pc bits, decode side
    logic [PC_BITS-1:0]  pc_up;         // low pc bits, execute side
    logic [GR_BITS-1:0]  gr;            // global history, newest in bit 0
    logic [IDX_BITS-1:0] idx_rd;
    logic [IDX_BITS-1:0] idx_up;

    assign taken = (pipe_in.br_res == B_T);
    assign pc_rd = pipe_in.pc_dec[PC_BITS-1:0];
    assign pc_up = pipe_in.pc_exe[PC_BITS-1:0];

    // history shifts in the outcome on every resolve
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            gr <= '0;
        end else if (pipe_in.spec.resolve) begin
            gr <= GR_BITS'({gr, taken});
        end
    end

    // --------------------------------------------------
    // index formation
    // --------------------------------------------------
    if ((BP_TYPE_SEL == BP_BIMODAL) || (BP_TYPE_SEL == BP_COMBINED)) begin : gen_idx_pc
        assign idx_rd = pc_rd;
        assign idx_up = pc_up;
    end else if (BP_TYPE_SEL == BP_GLOBAL) begin : gen_idx_gr
        assign idx_rd = gr;     // history moves with the table, same edge
        assign idx_up = gr;
    end else if (BP_TYPE_SEL == BP_GSELECT) begin : gen_idx_gsel
        assign idx_rd = {pc_rd, gr};
        assign idx_up = {pc_up, gr};
    end else begin : gen_idx_gshare
        // history aligned to the top of the index when pc is wider
        localparam int unsigned GR_OFF = (PC_BITS > GR_BITS) ? (PC_BITS - GR_BITS) : 0;
        assign idx_rd = IDX_BITS'(pc_rd) ^ (IDX_BITS'(gr) << GR_OFF);
        assign idx_up = IDX_BITS'(pc_up) ^ (IDX_BITS'(gr) << GR_OFF);
    end

    // --------------------------------------------------
    // counter table
    // --------------------------------------------------
    logic [CNT_BITS-1:0] pht [ENTRIES];
    logic                step_en;       // counter moves this resolve
    logic                step_up;       // direction of the move
    logic                hi;            // read counter at or above threshold

    assign hi = (pht[idx_rd] >= THR);

    if (BP_TYPE_SEL == BP_COMBINED) begin : gen_chooser
        bp_comp_t pred_made;    // component guesses of the branch in flight

        always_ff @(posedge clk) begin
            if (pipe_in.spec.enter) begin
                pred_made <= bp_comp_pred;
            end
        end

        // move toward bimodal when it hit, only if the two disagreed
        assign step_en = (pred_made.bp_1_p != pred_made.bp_2_p);
        assign step_up = (pred_made.bp_1_p == pipe_in.br_res);
        assign pred    = hi ? bp_comp_pred.bp_1_p : bp_comp_pred.bp_2_p;
    end else begin : gen_direction
        assign step_en = 1'b1;
        assign step_up = taken;
        assign pred    = hi ? B_T : B_NT;
    end

    // saturating update at the resolve edge
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < ENTRIES; i++) begin
                pht[i] <= THR;              // weak taken / weak bimodal bias
            end
        end else if (pipe_in.spec.resolve && step_en) begin
            if (step_up) begin
                if (pht[idx_up] != TOP) pht[idx_up] <= pht[idx_up] + 1'b1;
            end else begin
                if (pht[idx_up] != '0) pht[idx_up] <= pht[idx_up] - 1'b1;
            end
        end
    end

endmodule

// File: hw/bp_branch_track.sv
`timescale 1ns/1ps

module bp_branch_track (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dec_branch,
    input  bp_param_pkg::pc_t      dec_pc,
    input  logic                   exe_resolve,
    input  logic                   exe_taken,
    input  bp_pipe_pkg::bp_cfg_t   cfg,
    input  bp_pipe_pkg::bp_comp_t  comp_pred,
    input  bp_param_pkg::branch_t  chooser_pred,
    output bp_pipe_pkg::bp_pipe_t  pipe_out,
    output logic                   pred_valid,
    output bp_param_pkg::branch_t  pred,
    output logic                   busy
);

    import bp_param_pkg::*;

    logic in_flight;    // one branch between decode and execute
    pc_t  pc_q;         // pc of that branch
    logic enter;
    logic resolve;

    // --------------------------------------------------
    // speculation strobes
    // --------------------------------------------------
    assign resolve = exe_resolve && in_flight;              // stray resolves dropped
    assign enter   = dec_branch && (!in_flight || resolve); // slot free or freeing

    always_ff @(posedge clk) begin
        if (rst || cfg.flush) begin
            in_flight <= 1'b0;
        end else if (enter) begin
            in_flight <= 1'b1;
        end else if (resolve) begin
            in_flight <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (enter) pc_q <= dec_pc;
    end

    assign pipe_out.pc_dec       = dec_pc;
    assign pipe_out.pc_exe       = pc_q;
    assign pipe_out.br_res       = exe_taken ? B_T : B_NT;
    assign pipe_out.spec.enter   = enter;
    assign pipe_out.spec.resolve = resolve;

    // --------------------------------------------------
    // final prediction
    // --------------------------------------------------
    always_comb begin
        if (!cfg.enable) begin
            pred = B_NT;                        // still tracked and trained
        end else begin
            case (cfg.mode)
                MODE_BIMODAL: pred = comp_pred.bp_1_p;
                MODE_GSHARE:  pred = comp_pred.bp_2_p;
                default:      pred = chooser_pred;   // combined, unused code too
            endcase
        end
    end

    assign pred_valid = enter;
    assign busy       = dec_branch && !enter;   // decode branch dropped
endmodule

// File: hw/bp_ctrl_regs.sv
`timescale 1ns/1ps

module bp_ctrl_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cfg_we,
    input  logic [3:0]            cfg_wdata,
    output bp_pipe_pkg::bp_cfg_t  cfg
);

    import bp_param_pkg::*;

    logic     enable_q;
    bp_mode_t mode_q;
    logic     flush_q;

    // --------------------------------------------------
    // write side
    // bit 0 enable, bits 2:1 mode, bit 3 flush
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            enable_q <= 1'b1;
            mode_q   <= MODE_COMBINED;
        end else if (cfg_we) begin
            enable_q <= cfg_wdata[0];
            mode_q   <= bp_mode_t'(cfg_wdata[2:1]);
        end
    end

    // flush is not sticky, high for one cycle after the write
    always_ff @(posedge clk) begin
        if (rst) flush_q <= 1'b0;
        else     flush_q <= cfg_we && cfg_wdata[3];
    end

    assign cfg.enable = enable_q;
    assign cfg.mode   = mode_q;
    assign cfg.flush  = flush_q;

endmodule

// File: hw/bp_top.sv
`timescale 1ns/1ps

module bp_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dec_branch,
    input  bp_param_pkg::pc_t     dec_pc,
    input  logic                  exe_resolve,
    input  logic                  exe_taken,
    input  logic                  cfg_we,
    input  logic [3:0]            cfg_wdata,
    output logic                  pred_valid,
    output bp_param_pkg::branch_t pred,
    output logic                  busy
);

    import bp_param_pkg::*;
    import bp_pipe_pkg::*;

    bp_pipe_t pipe;         // tracker to all tables
    bp_comp_t comp;         // bimodal and gshare guesses
    bp_cfg_t  cfg;
    branch_t  chooser_pred; // chosen component guess

    // --------------------------------------------------
    // config and tracking
    // --------------------------------------------------
    bp_ctrl_regs i_ctrl_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    bp_branch_track i_branch_track (
        .clk          (clk),
        .rst          (rst),
        .dec_branch   (dec_branch),
        .dec_pc       (dec_pc),
        .exe_resolve  (exe_resolve),
        .exe_taken    (exe_taken),
        .cfg          (cfg),
        .comp_pred    (comp),
        .chooser_pred (chooser_pred),
        .pipe_out     (pipe),
        .pred_valid   (pred_valid),
        .pred         (pred),
        .busy         (busy)
    );

    // --------------------------------------------------
    // tables, components feed the chooser
    // --------------------------------------------------
    bp_pht #(
        .BP_TYPE_SEL (BP_BIMODAL),
        .PC_BITS     (PC_BITS),
        .GR_BITS     (GR_BITS),
        .CNT_BITS    (CNT_BITS)
    ) i_bimodal (
        .clk          (clk),
        .rst          (rst),
        .flush        (cfg.flush),
        .pipe_in      (pipe),
        .bp_comp_pred ('0),         // components ignore it
        .pred         (comp.bp_1_p)
    );

    bp_pht #(
        .BP_TYPE_SEL (BP_GSHARE),
        .PC_BITS     (PC_BITS),
        .GR_BITS     (GR_BITS),
        .CNT_BITS    (CNT_BITS)
    ) i_gshare (
        .clk          (clk),
        .rst          (rst),
        .flush        (cfg.flush),
        .pipe_in      (pipe),
        .bp_comp_pred ('0),
        .pred         (comp.bp_2_p)
    );

    bp_pht #(
        .BP_TYPE_SEL (BP_COMBINED),
        .PC_BITS     (PC_BITS),
        .GR_BITS     (GR_BITS),
        .CNT_BITS    (CNT_BITS)
    ) i_chooser (
        .clk          (clk),
        .rst          (rst),
        .flush        (cfg.flush),
        .pipe_in      (pipe),
        .bp_comp_pred (comp),
        .pred         (chooser_pred)
    );

endmodule

// File: dv/bp_tb.sv
`timescale 1ns/1ps

module bp_tb;

    import bp_param_pkg::*;

    // --------------------------------------------------
    // run length and watchdog
    // --------------------------------------------------
    localparam int N_ENTRY     = 1 << PC_BITS;
    localparam int RAND_LEN    = 400;                       // cycles per random stream
    localparam int TEST_CYCLES = 20 + 10 + 5 * (RAND_LEN + 1);
    localparam int LIMIT_NS    = (TEST_CYCLES + 100) * 20;  // plus margin
    localparam logic [CNT_BITS-1:0] THR_CNT = CNT_BITS'(CNT_THR);
    localparam logic [CNT_BITS-1:0] MAX_CNT = CNT_BITS'(CNT_MAX);
    localparam pc_t PC_BASE = 32'h0000_0400;

    logic clk = 1'b0;
    logic rst, dec_branch, exe_resolve, exe_taken, cfg_we, pred_valid, busy;
    logic [3:0] cfg_wdata;
    pc_t dec_pc;
    branch_t pred;

    // reference model state
    logic [CNT_BITS-1:0] m_bim [N_ENTRY];
    logic [CNT_BITS-1:0] m_gsh [N_ENTRY];
    logic [CNT_BITS-1:0] m_cho [N_ENTRY];
    ghr_t m_ghr_g;                  // gshare history, newest in bit 0
    logic m_in_flight, m_p1_q, m_p2_q, m_enable, m_flush_q;
    pc_t m_pc_q;
    bp_mode_t m_mode;

    integer seed = 39895;
    int errors = 0, test_errors = 0, test_checks = 0, tests = 0;
    logic last_valid, last_busy;
    branch_t last_pred;

    bp_top i_dut (.*);

    always #10 clk = ~clk;

    initial begin
        #(LIMIT_NS);
        $display("timeout: run did not finish within %0d ns", LIMIT_NS);
        $display("Errors found");
        $finish;
    end

    function automatic logic [CNT_BITS-1:0] step_counter(input logic [CNT_BITS-1:0] c,
                                                        input logic up);
        if (up) return (c == MAX_CNT) ? c : c + 1'b1;
        return (c == '0) ? c : c - 1'b1;
    endfunction

    task automatic clear_tables();
        for (int i = 0; i < N_ENTRY; i++) begin
            m_bim[i] = THR_CNT;
            m_gsh[i] = THR_CNT;
            m_cho[i] = THR_CNT;
        end
        m_ghr_g = '0;
        m_in_flight = 1'b0;
    endtask

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    // --------------------------------------------------
    // one clock cycle, drive / check / model step
    // --------------------------------------------------
    task automatic cycle(input logic dec, input pc_t pc, input logic res, input logic tk,
                         input logic we, input logic [3:0] wd);
        logic resolve, enter, p1, p2, chosen, exp_pred;
        logic [PC_BITS-1:0] ib, ig, iu;
        dec_branch = dec;                   // we sit 1 ns past the edge
        dec_pc = pc;
        exe_resolve = res;
        exe_taken = tk;
        cfg_we = we;
        cfg_wdata = wd;
        resolve = res && m_in_flight;       // stray resolve ignored
        enter = dec && (!m_in_flight || resolve);
        ib = pc[PC_BITS-1:0];
        ig = ib ^ m_ghr_g;                  // gshare index
        p1 = (m_bim[ib] >= THR_CNT);
        p2 = (m_gsh[ig] >= THR_CNT);
        chosen = (m_cho[ib] >= THR_CNT) ? p1 : p2;
        if (!m_enable) exp_pred = 1'b0;
        else if (m_mode == MODE_BIMODAL) exp_pred = p1;
        else if (m_mode == MODE_GSHARE) exp_pred = p2;
        else exp_pred = chosen;
        #8;                                 // outputs settled mid cycle
        test_checks++;
        assert (pred_valid === enter) else begin
            $display("MISMATCH pred_valid: got %h expected %h", pred_valid, enter);
            count_error();
        end
        assert (busy === (dec && !enter)) else begin
            $display("MISMATCH busy: got %h expected %h", busy, dec && !enter);
            count_error();
        end
        if (enter) begin
            assert (pred === exp_pred) else begin
                $display("MISMATCH pred: got %h expected %h pc %h", pred, exp_pred, pc);
                count_error();
            end
        end
        last_valid = pred_valid;
        last_pred = pred;
        last_busy = busy;
        // model state at the coming edge
        if (m_flush_q) begin
            clear_tables();
        end else begin
            if (resolve) begin
                iu = m_pc_q[PC_BITS-1:0];
                m_bim[iu] = step_counter(m_bim[iu], tk);
                m_gsh[iu ^ m_ghr_g] = step_counter(m_gsh[iu ^ m_ghr_g], tk);
                if (m_p1_q != m_p2_q) m_cho[iu] = step_counter(m_cho[iu], m_p1_q == tk);
                m_ghr_g = {m_ghr_g[GR_BITS-2:0], tk};
            end
            if (enter) m_in_flight = 1'b1;
            else if (resolve) m_in_flight = 1'b0;
        end
        if (enter) begin                    // latched even in a flush cycle
            m_pc_q = pc;
            m_p1_q = p1;
            m_p2_q = p2;
        end
        if (we) begin
            m_enable = wd[0];
            m_mode = bp_mode_t'(wd[2:1]);
        end
        m_flush_q = we && wd[3];
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        tests++;
        test_errors = 0;
        test_checks = 0;
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic cold_start();
        cycle(1'b1, PC_BASE, 1'b0, 1'b0, 1'b0, 4'h0);
        assert (last_valid && last_pred == B_T) else begin
            $display("first prediction after reset was not taken");
            count_error();
        end
        cycle(1'b0, '0, 1'b1, 1'b0, 1'b0, 4'h0);     // train it not taken
        cycle(1'b0, '0, 1'b0, 1'b0, 1'b1, 4'b1001);  // flush, enable, combined
        repeat (2) cycle(1'b0, '0, 1'b0, 1'b0, 1'b0, 4'h0);
        cycle(1'b1, PC_BASE, 1'b0, 1'b0, 1'b0, 4'h0);
        assert (last_valid && last_pred == B_T) else begin
            $display("first prediction after flush was not taken");
            count_error();
        end
        cycle(1'b0, '0, 1'b1, 1'b1, 1'b0, 4'h0);
        finish_test("cold_start");
    endtask

    task automatic stall();
        cycle(1'b1, PC_BASE + 32'h8, 1'b0, 1'b0, 1'b0, 4'h0);
        repeat (4) begin
            cycle(1'b1, PC_BASE + 32'hc, 1'b0, 1'b0, 1'b0, 4'h0);
            assert (!last_valid && last_busy) else begin
                $display("branch accepted while another one was in flight");
                count_error();
            end
        end
        cycle(1'b0, '0, 1'b1, 1'b1, 1'b0, 4'h0);
        finish_test("stall");
    endtask

    task automatic random_stream(input string name, input logic [3:0] wd);
        logic [31:0] r;
        cycle(1'b0, '0, 1'b0, 1'b0, 1'b1, wd);
        repeat (RAND_LEN) begin
            r = $random(seed);
            // outcome leans on the pc so the tables have something to learn
            cycle(r[1:0] != 2'b00, PC_BASE + pc_t'({r[4:2], 2'b00}), r[5],
                  r[4] ^ (r[9:7] == 3'b000), 1'b0, 4'h0);
        end
        finish_test(name);
    endtask

    initial begin
        rst = 1'b1;
        dec_branch = 1'b0;
        dec_pc = '0;
        exe_resolve = 1'b0;
        exe_taken = 1'b0;
        cfg_we = 1'b0;
        cfg_wdata = '0;
        clear_tables();
        m_enable = 1'b1;
        m_mode = MODE_COMBINED;
        m_flush_q = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        cold_start();
        stall();
        random_stream("bimodal", 4'b0011);
        random_stream("gshare", 4'b0101);
        random_stream("combined", 4'b0001);
        random_stream("disabled", 4'b0000);
        random_stream("reenabled", 4'b0001);
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: filelist.f
hw/bp_param_pkg.sv
hw/bp_pipe_pkg.sv
hw/bp_pht.sv
hw/bp_branch_track.sv
hw/bp_ctrl_regs.sv
hw/bp_top.sv
dv/bp_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module bp_tb -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vbp_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^No errors$"; then
    exit 0
fi
exit 1
